/* verilog/seq_pkg.sv */
/*
  Shared sizes and types of the vector instruction sequencer.
  Four functional units, 8 instruction IDs and 32 vector registers.
  CNT_W must be wide enough to hold the largest queue depth.
  Field order inside the structs is fixed because the testbench builds
  and reads these words bit by bit.
*/
package seq_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Instructions in flight at once
  localparam int unsigned NR_VINSN = 8;
  // Architectural vector registers
  localparam int unsigned NR_VREGS = 32;
  // ALU, MUL, LOAD, STORE
  localparam int unsigned NR_UNITS = 4;
  // Occupancy counter width
  localparam int unsigned CNT_W = 3;

  typedef logic [$clog2(NR_VINSN)-1:0] vid_t;
  typedef logic [$clog2(NR_VREGS)-1:0] vreg_t;
  // One bit per instruction ID
  typedef logic [NR_VINSN-1:0] vinsn_vec_t;

  // Functional units, also the index of each unit tracker
  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_MUL   = 2'd1,
    UNIT_LOAD  = 2'd2,
    UNIT_STORE = 2'd3
  } unit_e;

  // Queue depth per unit, slice 0 is the ALU
  localparam logic [NR_UNITS-1:0][CNT_W-1:0] UNIT_DEPTH = {3'd2, 3'd2, 3'd2, 3'd4};

  ////////////////////////////////////////////////////////////////////////////
  // Request and bookkeeping structs
  ////////////////////////////////////////////////////////////////////////////

  // Request from the dispatcher
  typedef struct packed {
    unit_e unit;
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    logic  use_vd;
    logic  use_vs1;
    logic  use_vs2;
  } vreq_t;

  // Request issued to the processing elements
  typedef struct packed {
    vid_t       id;
    unit_e      unit;
    vreg_t      vd;
    vreg_t      vs1;
    vreg_t      vs2;
    logic       use_vd;
    logic       use_vs1;
    logic       use_vs2;
    vinsn_vec_t hazard_vs1;
    vinsn_vec_t hazard_vs2;
    vinsn_vec_t hazard_vd;
  } pe_req_t;

  // Reader or writer of one vector register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  // Completion report, also used for the allocation pulse
  typedef struct packed {
    logic valid;
    vid_t id;
  } unit_done_t;

endpackage

/* verilog/issue_ctrl.sv */
/*
  Issue stage of the sequencer. One request is taken at a time and gets
  the lowest free instruction ID. Register-list entries arrive unmasked
  and are filtered here with the running vector.
  Only one issued request is held. While it is stalled by the PEs no
  new request is accepted, so the held word never changes.
*/
module issue_ctrl import seq_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Dispatcher side
  input  vreq_t               vreq_i,
  input  logic                vreq_valid_i,
  output logic                vreq_ready_o,
  // Unit and ID status
  input  logic [NR_UNITS-1:0] unit_room_i,
  input  vinsn_vec_t          vinsn_running_i,
  // Register-list lookups for the current request
  input  vreg_access_t        wr_vd_i,
  input  vreg_access_t        wr_vs1_i,
  input  vreg_access_t        wr_vs2_i,
  input  vreg_access_t        rd_vd_i,
  // PE side
  input  logic                pe_req_ready_i,
  output pe_req_t             pe_req_o,
  output logic                pe_req_valid_o,
  // Allocation towards trackers and hazard table
  output unit_e               acc_unit_o,
  output unit_done_t          alloc_o,
  output vinsn_vec_t          row_o
);

  // One-hot of a list entry, only if it is used and still running
  function automatic vinsn_vec_t entry_vec(vreg_access_t entry, logic use_en,
                                           vinsn_vec_t running);
    vinsn_vec_t vec;
    vec = '0;
    if (use_en && entry.valid && running[entry.vid]) begin
      vec[entry.vid] = 1'b1;
    end
    return vec;
  endfunction

  vid_t       free_id;
  logic       id_free;
  logic       pe_stall;
  logic       accept;
  vinsn_vec_t war_vec;
  vinsn_vec_t haz_vs1;
  vinsn_vec_t haz_vs2;
  vinsn_vec_t haz_vd;
  pe_req_t    pe_req_d;
  pe_req_t    pe_req_q;
  logic       pe_req_valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // ID allocation
  ////////////////////////////////////////////////////////////////////////////

  // Priority encoder, lowest free ID wins
  always_comb begin : p_free_id
    free_id = '0;
    id_free = 1'b0;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (!vinsn_running_i[i]) begin
        free_id = vid_t'(i);
        id_free = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Hazard lookup
  ////////////////////////////////////////////////////////////////////////////

  // WAR, new vd is read by a running instruction
  assign war_vec = entry_vec(rd_vd_i, vreq_i.use_vd, vinsn_running_i);

  // RAW on the sources, WAR folded into both
  assign haz_vs1 = entry_vec(wr_vs1_i, vreq_i.use_vs1, vinsn_running_i) | war_vec;
  assign haz_vs2 = entry_vec(wr_vs2_i, vreq_i.use_vs2, vinsn_running_i) | war_vec;
  // WAW
  assign haz_vd  = entry_vec(wr_vd_i, vreq_i.use_vd, vinsn_running_i);

  // Row of the global table for this ID
  assign row_o = haz_vs1 | haz_vs2 | haz_vd;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake and issue register
  ////////////////////////////////////////////////////////////////////////////

  // Held request not taken by the PEs yet
  assign pe_stall = pe_req_valid_q & ~pe_req_ready_i;

  assign vreq_ready_o = id_free & unit_room_i[vreq_i.unit] & ~pe_stall;
  assign accept       = vreq_valid_i & vreq_ready_o;

  assign acc_unit_o = vreq_i.unit;
  assign alloc_o    = '{valid: accept, id: free_id};

  assign pe_req_d = '{
    id        : free_id,
    unit      : vreq_i.unit,
    vd        : vreq_i.vd,
    vs1       : vreq_i.vs1,
    vs2       : vreq_i.vs2,
    use_vd    : vreq_i.use_vd,
    use_vs1   : vreq_i.use_vs1,
    use_vs2   : vreq_i.use_vs2,
    hazard_vs1: haz_vs1,
    hazard_vs2: haz_vs2,
    hazard_vd : haz_vd
  };

  // Payload only moves on accept, which never happens during a stall
  always_ff @(posedge clk_i) begin : p_pe_req
    if (accept) begin
      pe_req_q <= pe_req_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_pe_req_valid
    if (!rst_ni) begin
      pe_req_valid_q <= 1'b0;
    end else if (!pe_stall) begin
      pe_req_valid_q <= accept;
    end
  end

  assign pe_req_o       = pe_req_q;
  assign pe_req_valid_o = pe_req_valid_q;

endmodule

/* verilog/reg_scoreboard.sv */
/*
  Per-register reader and writer lists. Each register remembers only
  its last writer and its last reader.
  Entries of finished IDs are dropped one cycle after the running bit
  falls. Lookups return raw entries, the consumer masks them with the
  running vector itself.
*/
module reg_scoreboard import seq_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  // Current request and its allocation
  input  vreq_t        vreq_i,
  input  logic         accept_i,
  input  vid_t         vid_i,
  input  vinsn_vec_t   vinsn_running_i,
  // Lookups for the current request
  output vreg_access_t wr_vd_o,
  output vreg_access_t wr_vs1_o,
  output vreg_access_t wr_vs2_o,
  output vreg_access_t rd_vd_o
);

  vreg_access_t [NR_VREGS-1:0] writer_d;
  vreg_access_t [NR_VREGS-1:0] writer_q;
  vreg_access_t [NR_VREGS-1:0] reader_d;
  vreg_access_t [NR_VREGS-1:0] reader_q;

  ////////////////////////////////////////////////////////////////////////////
  // List update
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_lists
    writer_d = writer_q;
    reader_d = reader_q;

    // Retire entries whose instruction is gone
    for (int unsigned r = 0; r < NR_VREGS; r++) begin
      writer_d[r].valid = writer_q[r].valid & vinsn_running_i[writer_q[r].vid];
      reader_d[r].valid = reader_q[r].valid & vinsn_running_i[reader_q[r].vid];
    end

    // New instruction overrides retirement on the same register
    if (accept_i) begin
      if (vreq_i.use_vd) begin
        writer_d[vreq_i.vd] = '{vid: vid_i, valid: 1'b1};
      end
      if (vreq_i.use_vs1) begin
        reader_d[vreq_i.vs1] = '{vid: vid_i, valid: 1'b1};
      end
      if (vreq_i.use_vs2) begin
        reader_d[vreq_i.vs2] = '{vid: vid_i, valid: 1'b1};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lists_ff
    if (!rst_ni) begin
      writer_q <= '0;
      reader_q <= '0;
    end else begin
      writer_q <= writer_d;
      reader_q <= reader_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////

  // RAW sources and WAW target
  assign wr_vd_o  = writer_q[vreq_i.vd];
  assign wr_vs1_o = writer_q[vreq_i.vs1];
  assign wr_vs2_o = writer_q[vreq_i.vs2];
  // WAR target
  assign rd_vd_o  = reader_q[vreq_i.vd];

endmodule

/* verilog/unit_tracker.sv */
/*
  Occupancy counter and running-ID mask of one functional unit.
  UNIT_IDX selects the unit and its queue depth.
  A done report is trusted to name an ID that runs on this unit.
*/
module unit_tracker import seq_pkg::*; #(
  parameter int unsigned UNIT_IDX = 0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Allocation broadcast from the issue stage
  input  unit_e      acc_unit_i,
  input  unit_done_t alloc_i,
  // Completion from this unit
  input  unit_done_t done_i,
  output logic       room_o,
  output vinsn_vec_t running_o
);

  logic [CNT_W-1:0] cnt_d;
  logic [CNT_W-1:0] cnt_q;
  vinsn_vec_t       running_d;
  vinsn_vec_t       running_q;
  logic             cnt_up;
  logic             cnt_down;

  // Allocation only counts when it targets this unit
  assign cnt_up   = alloc_i.valid & (acc_unit_i == unit_e'(UNIT_IDX));
  assign cnt_down = done_i.valid;

  always_comb begin : p_next
    // Up and down together leave the count alone
    case ({cnt_up, cnt_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase

    running_d = running_q;
    if (cnt_down) begin
      running_d[done_i.id] = 1'b0;
    end
    // A fresh ID is never the one finishing
    if (cnt_up) begin
      running_d[alloc_i.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      cnt_q     <= '0;
      running_q <= '0;
    end else begin
      cnt_q     <= cnt_d;
      running_q <= running_d;
    end
  end

  assign room_o    = cnt_q < UNIT_DEPTH[UNIT_IDX];
  assign running_o = running_q;

endmodule

/* verilog/hazard_table.sv */
/*
  Global hazard table for the operand requesters. Row N lists the
  running IDs that instruction N waits on.
  Rows are only cleaned by the running vector, so the row of a finished
  ID keeps whatever bits still run until it is reallocated.
  Idle comes from registered unit masks only.
*/
module hazard_table import seq_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  vinsn_vec_t [NR_UNITS-1:0]    unit_running_i,
  // New row and its ID
  input  unit_done_t                   alloc_i,
  input  vinsn_vec_t                   row_i,
  output vinsn_vec_t                   vinsn_running_o,
  output vinsn_vec_t [NR_VINSN-1:0]    hazard_table_o,
  output logic                         idle_o
);

  vinsn_vec_t                vinsn_running;
  vinsn_vec_t [NR_VINSN-1:0] hz_table_d;
  vinsn_vec_t [NR_VINSN-1:0] hz_table_q;

  // An ID runs if any unit holds it
  always_comb begin : p_running
    vinsn_running = '0;
    for (int unsigned u = 0; u < NR_UNITS; u++) begin
      vinsn_running |= unit_running_i[u];
    end
  end

  always_comb begin : p_table
    // Drop finished dependencies
    for (int unsigned i = 0; i < NR_VINSN; i++) begin
      hz_table_d[i] = hz_table_q[i] & vinsn_running;
    end
    // Row of the newly issued ID
    if (alloc_i.valid) begin
      hz_table_d[alloc_i.id] = row_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_table_ff
    if (!rst_ni) begin
      hz_table_q <= '0;
    end else begin
      hz_table_q <= hz_table_d;
    end
  end

  assign vinsn_running_o = vinsn_running;
  assign hazard_table_o  = hz_table_q;
  assign idle_o          = ~|vinsn_running;

endmodule

/* verilog/vseq_top.sv */
/*
  Top level of the vector instruction sequencer.
  Request in, registered PE request out one cycle after acceptance.
  One completion report per unit per cycle, each naming an ID that is
  running on that unit.
*/
module vseq_top import seq_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Dispatcher
  input  vreq_t                        vreq_i,
  input  logic                         vreq_valid_i,
  output logic                         vreq_ready_o,
  // Processing elements
  output pe_req_t                      pe_req_o,
  output logic                         pe_req_valid_o,
  input  logic                         pe_req_ready_i,
  input  unit_done_t [NR_UNITS-1:0]    unit_done_i,
  // Operand requesters
  output vinsn_vec_t [NR_VINSN-1:0]    hazard_table_o,
  output logic                         idle_o
);

  unit_e                     acc_unit;
  unit_done_t                alloc;
  vinsn_vec_t                row;
  vinsn_vec_t                vinsn_running;
  logic       [NR_UNITS-1:0] unit_room;
  vinsn_vec_t [NR_UNITS-1:0] unit_running;
  vreg_access_t              wr_vd;
  vreg_access_t              wr_vs1;
  vreg_access_t              wr_vs2;
  vreg_access_t              rd_vd;

  ////////////////////////////////////////////////////////////////////////////
  // Issue and register lists
  ////////////////////////////////////////////////////////////////////////////

  issue_ctrl i_issue_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .vreq_i         (vreq_i),
    .vreq_valid_i   (vreq_valid_i),
    .vreq_ready_o   (vreq_ready_o),
    .unit_room_i    (unit_room),
    .vinsn_running_i(vinsn_running),
    .wr_vd_i        (wr_vd),
    .wr_vs1_i       (wr_vs1),
    .wr_vs2_i       (wr_vs2),
    .rd_vd_i        (rd_vd),
    .pe_req_ready_i (pe_req_ready_i),
    .pe_req_o       (pe_req_o),
    .pe_req_valid_o (pe_req_valid_o),
    .acc_unit_o     (acc_unit),
    .alloc_o        (alloc),
    .row_o          (row)
  );

  reg_scoreboard i_reg_scoreboard (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .vreq_i         (vreq_i),
    .accept_i       (alloc.valid),
    .vid_i          (alloc.id),
    .vinsn_running_i(vinsn_running),
    .wr_vd_o        (wr_vd),
    .wr_vs1_o       (wr_vs1),
    .wr_vs2_o       (wr_vs2),
    .rd_vd_o        (rd_vd)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Unit trackers and hazard table
  ////////////////////////////////////////////////////////////////////////////

  // Index matches the unit_e encoding
  for (genvar u = 0; u < NR_UNITS; u++) begin : gen_unit
    unit_tracker #(
      .UNIT_IDX(u)
    ) i_unit_tracker (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .acc_unit_i(acc_unit),
      .alloc_i   (alloc),
      .done_i    (unit_done_i[u]),
      .room_o    (unit_room[u]),
      .running_o (unit_running[u])
    );
  end

  hazard_table i_hazard_table (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .unit_running_i (unit_running),
    .alloc_i        (alloc),
    .row_i          (row),
    .vinsn_running_o(vinsn_running),
    .hazard_table_o (hazard_table_o),
    .idle_o         (idle_o)
  );

endmodule

/* sim/tb_clk_gen.sv */
/*
  Clock and reset source of the testbench.
  Reset is released on a falling edge so no flop sees it change
  together with a rising clock edge.
*/
module tb_clk_gen #(
  parameter int unsigned PERIOD     = 20,
  parameter int unsigned RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);

  // Free-running clock, 50% duty
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Active-low reset held for RST_CYCLES rising edges
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* sim/tb_vseq.sv */
/*
  Testbench of the vector instruction sequencer.
  Commands and expected values come from sim/vseq_stimulus.txt, run
  from the project root. Inputs change on rising edges, outputs are
  sampled on falling edges. A STALL applies to the next REQ line.
  A REQ with refuse cycles leaves its request pending, the next REQ
  line must repeat the same request.
*/
module tb_vseq import seq_pkg::*; ();

  localparam string STIM_FILE = "sim/vseq_stimulus.txt";
  // Watchdog budget per stimulus line
  localparam int unsigned CYCLES_PER_LINE = 200;

  logic                      clk_i;
  logic                      rst_ni;
  vreq_t                     vreq_i;
  logic                      vreq_valid_i;
  logic                      vreq_ready_o;
  pe_req_t                   pe_req_o;
  logic                      pe_req_valid_o;
  logic                      pe_req_ready_i;
  unit_done_t [NR_UNITS-1:0] unit_done_i;
  vinsn_vec_t [NR_VINSN-1:0] hazard_table_o;
  logic                      idle_o;

  // Acceptances counted on the falling edge before each one
  int unsigned accept_cnt;
  int unsigned hold_cnt;
  bit          holding;
  int unsigned stall_len;
  int unsigned wd_cycles;
  bit          test_ok;
  int unsigned tests_run;
  int unsigned fail_cnt;

  // Fields of one stimulus line
  int          fd;
  int          n;
  int unsigned n_lines;
  int          f_unit;
  int          f_vd;
  int          f_vs1;
  int          f_vs2;
  int          f_uvd;
  int          f_uvs1;
  int          f_uvs2;
  int          f_blk;
  int          f_id;
  logic [7:0]  f_h1;
  logic [7:0]  f_h2;
  logic [7:0]  f_hd;
  logic [7:0]  f_row;
  reg [8*32-1:0]  cmd;
  reg [8*32-1:0]  name;
  reg [8*128-1:0] linebuf;

  tb_clk_gen #(
    .PERIOD    (20),
    .RST_CYCLES(4)
  ) i_clk_gen (
    .clk_o (clk_i),
    .rst_no(rst_ni)
  );

  vseq_top i_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .vreq_i        (vreq_i),
    .vreq_valid_i  (vreq_valid_i),
    .vreq_ready_o  (vreq_ready_o),
    .pe_req_o      (pe_req_o),
    .pe_req_valid_o(pe_req_valid_o),
    .pe_req_ready_i(pe_req_ready_i),
    .unit_done_i   (unit_done_i),
    .hazard_table_o(hazard_table_o),
    .idle_o        (idle_o)
  );

  // Handshake seen on the falling edge completes on the next rising edge
  always @(negedge clk_i) begin
    if (vreq_valid_i && vreq_ready_o) begin
      accept_cnt <= accept_cnt + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Command tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input reg [8*32-1:0] tname, input reg [8*16-1:0] field,
                             input logic [63:0] exp, input logic [63:0] act);
    assert (exp == act) else begin
      $display("FAIL %0s %0s expected %0h actual %0h", tname, field, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic drive_request(input reg [8*32-1:0] tname, input vreq_t req, input int blk,
                               input int exp_id, input logic [7:0] h1,
                               input logic [7:0] h2, input logic [7:0] hd);
    int unsigned cnt0;
    pe_req_t     held;
    @(posedge clk_i);
    // A refused request stays on the bus
    if (holding) begin
      cnt0 = hold_cnt;
    end else begin
      cnt0         = accept_cnt;
      vreq_i       <= req;
      vreq_valid_i <= 1'b1;
    end
    if (blk > 0) begin
      repeat (blk) begin
        @(posedge clk_i);
        assert (accept_cnt == cnt0) else begin
          $display("ERROR %0s: request accepted although its unit was full", tname);
          test_ok = 1'b0;
        end
      end
      holding  = 1'b1;
      hold_cnt = cnt0;
    end else begin
      while (accept_cnt == cnt0) @(posedge clk_i);
      vreq_valid_i <= 1'b0;
      holding = 1'b0;
      // Issue register must be loaded one cycle after acceptance
      @(negedge clk_i);
      check_value(tname, "pe_req_valid", 1, pe_req_valid_o);
      check_value(tname, "id", exp_id, pe_req_o.id);
      check_value(tname, "unit", req.unit, pe_req_o.unit);
      check_value(tname, "vd", req.vd, pe_req_o.vd);
      check_value(tname, "vs1", req.vs1, pe_req_o.vs1);
      check_value(tname, "vs2", req.vs2, pe_req_o.vs2);
      check_value(tname, "use_vd", req.use_vd, pe_req_o.use_vd);
      check_value(tname, "use_vs1", req.use_vs1, pe_req_o.use_vs1);
      check_value(tname, "use_vs2", req.use_vs2, pe_req_o.use_vs2);
      check_value(tname, "hazard_vs1", h1, pe_req_o.hazard_vs1);
      check_value(tname, "hazard_vs2", h2, pe_req_o.hazard_vs2);
      check_value(tname, "hazard_vd", hd, pe_req_o.hazard_vd);
      held = pe_req_o;
      // Back-pressure armed by a STALL line
      if (stall_len > 0) begin
        repeat (stall_len) begin
          @(posedge clk_i);
          @(negedge clk_i);
          check_value(tname, "held pe_req", held, pe_req_o);
          check_value(tname, "held valid", 1, pe_req_valid_o);
          assert (!vreq_ready_o) else begin
            $display("ERROR %0s: new request could be accepted during a PE stall", tname);
            test_ok = 1'b0;
          end
        end
        @(posedge clk_i);
        pe_req_ready_i <= 1'b1;
        stall_len = 0;
      end
    end
  endtask

  task automatic drive_done(input int unit, input int id);
    @(posedge clk_i);
    unit_done_i[unit] <= '{valid: 1'b1, id: vid_t'(id)};
    @(posedge clk_i);
    unit_done_i <= '0;
  endtask

  task automatic arm_stall(input int cycles);
    @(posedge clk_i);
    pe_req_ready_i <= 1'b0;
    // Zero in the file picks a random length
    stall_len = (cycles == 0) ? $urandom_range(6, 2) : cycles;
  endtask

  task automatic check_row(input reg [8*32-1:0] tname, input int id, input logic [7:0] exp);
    // Table lags the running vector by one cycle
    @(posedge clk_i);
    @(negedge clk_i);
    check_value(tname, "row", exp, hazard_table_o[id]);
  endtask

  task automatic check_idle(input reg [8*32-1:0] tname, input int exp);
    @(posedge clk_i);
    @(negedge clk_i);
    check_value(tname, "idle", exp, idle_o);
  endtask

  task automatic count_lines(output int unsigned lines);
    int fd0;
    reg [8*128-1:0] buffer;
    lines = 0;
    fd0 = $fopen(STIM_FILE, "r");
    if (fd0 != 0) begin
      while (!$feof(fd0)) begin
        if ($fgets(buffer, fd0) != 0) begin
          lines++;
        end
      end
      $fclose(fd0);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin : p_watchdog
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk_i);
    $display("ERROR: no progress after %0d cycles, a handshake never completed", wd_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : p_main
    void'($urandom(32'h1845_1476));
    vreq_i         = '0;
    vreq_valid_i   = 1'b0;
    pe_req_ready_i = 1'b1;
    unit_done_i    = '0;
    accept_cnt     = 0;
    holding        = 1'b0;
    stall_len      = 0;
    wd_cycles      = 0;
    tests_run      = 0;
    fail_cnt       = 0;
    count_lines(n_lines);
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("ERROR: cannot open stimulus file %0s", STIM_FILE);
      $display("CHECKS FAILED");
      $finish;
    end else begin
      wd_cycles = CYCLES_PER_LINE * n_lines;
      wait (rst_ni);
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", cmd);
        if (n == 1 && cmd == "#") begin
          n = $fgets(linebuf, fd);
        end else if (n == 1) begin
          test_ok = 1'b1;
          name    = "unnamed";
          if (cmd == "REQ") begin
            n = $fscanf(fd, "%s %d %d %d %d %d %d %d %d %d %h %h %h", name, f_unit, f_vd,
                        f_vs1, f_vs2, f_uvd, f_uvs1, f_uvs2, f_blk, f_id, f_h1, f_h2, f_hd);
            drive_request(name, '{unit: unit_e'(f_unit), vd: vreg_t'(f_vd),
                                  vs1: vreg_t'(f_vs1), vs2: vreg_t'(f_vs2),
                                  use_vd: f_uvd[0], use_vs1: f_uvs1[0],
                                  use_vs2: f_uvs2[0]},
                          f_blk, f_id, f_h1, f_h2, f_hd);
          end else if (cmd == "DONE") begin
            n = $fscanf(fd, "%s %d %d", name, f_unit, f_id);
            drive_done(f_unit, f_id);
          end else if (cmd == "STALL") begin
            n = $fscanf(fd, "%s %d", name, f_blk);
            arm_stall(f_blk);
          end else if (cmd == "CHECK_IDLE") begin
            n = $fscanf(fd, "%s %d", name, f_id);
            check_idle(name, f_id);
          end else if (cmd == "CHECK_ROW") begin
            n = $fscanf(fd, "%s %d %h", name, f_id, f_row);
            check_row(name, f_id, f_row);
          end else begin
            $display("ERROR: unknown stimulus command %0s", cmd);
            n = $fgets(linebuf, fd);
            test_ok = 1'b0;
          end
          tests_run++;
          if (test_ok) begin
            $display("test %0s: pass", name);
          end else begin
            fail_cnt++;
            $display("test %0s: fail", name);
          end
        end
      end
      $fclose(fd);
      $display("%0d tests run, %0d passed, %0d failed", tests_run, tests_run - fail_cnt,
               fail_cnt);
      if (fail_cnt == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

/* sim/vseq_stimulus.txt */
# REQ name unit vd vs1 vs2 use_vd use_vs1 use_vs2 refuse_cycles exp_id hz_vs1 hz_vs2 hz_vd (hex)
# DONE name unit id / STALL name cycles (0 random) / CHECK_IDLE name idle / CHECK_ROW name id row (hex)
CHECK_IDLE reset_idle 1
CHECK_ROW reset_row0 0 00
REQ alloc_id0 0 1 2 3 1 1 1 0 0 00 00 00
REQ raw_vs1 1 4 1 5 1 1 1 0 1 01 00 00
REQ war_vd 2 2 0 0 1 0 0 0 2 01 01 00
REQ waw_vd 0 4 6 7 1 1 1 0 3 00 00 02
CHECK_ROW row_id1 1 01
CHECK_ROW row_id2 2 01
CHECK_ROW row_id3 3 02
CHECK_IDLE busy 0
DONE done_id0 0 0
CHECK_ROW row1_clean 1 00
CHECK_ROW row2_clean 2 00
REQ reuse_id0 0 8 1 2 1 1 1 0 0 00 04 00
REQ mul_second 1 9 10 11 1 1 1 0 4 00 00 00
REQ mul_full 1 12 9 13 1 1 1 3 1 10 00 00
DONE done_id1 1 1
REQ mul_after_done 1 12 9 13 1 1 1 0 1 10 00 00
STALL stall_pe 0
REQ store_stalled 3 20 8 12 0 1 1 0 5 01 02 00
CHECK_ROW row_id5 5 03
CHECK_ROW row_id0 0 04
DONE done_id2 2 2
CHECK_ROW row0_drop 0 00
DONE done_id0_again 0 0
CHECK_ROW row5_drop 5 02
DONE done_id3 0 3
DONE done_id4 1 4
DONE done_id1_again 1 1
CHECK_ROW row5_last 5 00
CHECK_IDLE still_busy 0
DONE done_id5 3 5
CHECK_IDLE all_done 1

/* vlog.f */
verilog/seq_pkg.sv
verilog/issue_ctrl.sv
verilog/reg_scoreboard.sv
verilog/unit_tracker.sv
verilog/hazard_table.sv
verilog/vseq_top.sv
sim/tb_clk_gen.sv
sim/tb_vseq.sv
